/* common/eval_params.svh */
`ifndef EVAL_PARAMS_SVH
`define EVAL_PARAMS_SVH

// Score and board geometry
`define EVAL_WIDTH 16          // Signed score bits
`define PIECE_WIDTH 4          // Colour bit plus piece code
`define SQUARE_COUNT 64        // Rank * 8 + file

// Tapered blend
`define PHASE_MAX 62           // Occupied squares at full middle game
`define TAPER_SHIFT 20         // Fixed-point scale of the 1/62 reciprocal
`define TAPER_RECIP 16912      // floor(2^20 / 62)
`define TAPER_LATENCY 5        // Register stages in the blend pipe

// Piece values, middle game and end game
`define PAWN_MG 82
`define PAWN_EG 94
`define KNIGHT_MG 337
`define KNIGHT_EG 281
`define BISHOP_MG 365
`define BISHOP_EG 297
`define ROOK_MG 477
`define ROOK_EG 512
`define QUEEN_MG 1025
`define QUEEN_EG 936

// Pawn structure penalties, per pawn
`define DOUBLED_MG 10
`define DOUBLED_EG 20
`define ISOLATED_MG 12
`define ISOLATED_EG 8

`endif

/* common/eval_pkg.sv */
`include "eval_params.svh"

package eval_pkg;

   // Piece codes, king carries no material value
   typedef enum logic [`PIECE_WIDTH-2:0]
   {
      EMPTY  = 3'd0,
      PAWN   = 3'd1,
      KNIGHT = 3'd2,
      BISHOP = 3'd3,
      ROOK   = 3'd4,
      QUEEN  = 3'd5,
      KING   = 3'd6
   } piece_t;

   typedef struct packed
   {
      logic   is_black;            // Colour of the piece
      piece_t kind;                // Piece code
   } square_t;

   // Square 0 is a1, square 63 is h8
   typedef square_t [`SQUARE_COUNT-1:0] board_t;

   typedef logic signed [`EVAL_WIDTH-1:0] score_t; // White positive

   // Middle-game and end-game terms of one evaluator
   typedef struct packed
   {
      score_t mg;
      score_t eg;
   } eval_pair_t;

   typedef logic [5:0] phase_t;    // 0 to PHASE_MAX

   typedef enum logic [1:0]
   {
      IDLE,                        // Tracking board_in
      WAIT_EVAL,                   // Evaluators running
      WAIT_LATENCY,                // Blend pipe draining
      WAIT_CLEAR                   // Result held
   } ctrl_state_t;

endpackage

/* evaluate/eval_control.sv */
`timescale 1ns/100ps
`include "eval_params.svh"

module eval_control
(
   input  logic              clk,
   input  logic              reset,
   input  logic              board_valid,
   input  eval_pkg::board_t  board_in,
   input  logic              clear_eval,
   input  logic [2:0]        terms_valid,   // {pawns black, pawns white, material}
   output eval_pkg::board_t  board,
   output logic              start,
   output logic              eval_valid
);

   localparam int LAT_WIDTH = $clog2(`TAPER_LATENCY + 1);

   eval_pkg::ctrl_state_t  state;
   eval_pkg::board_t       board_pre;    // First capture stage
   logic                   board_valid_r;
   logic                   board_edge;
   logic [LAT_WIDTH-1:0]   latency;      // Blend pipe cycles waited

   assign board_edge = board_valid & ~board_valid_r; // Rising edge only

   // Board is frozen outside IDLE, second stage is for timing
   always_ff @(posedge clk)
   begin
      if (state == eval_pkg::IDLE)
         board_pre <= board_in;       // Follow input until the edge
      board <= board_pre;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= eval_pkg::IDLE;
         board_valid_r <= 1'b0;
         start         <= 1'b0;
         eval_valid    <= 1'b0;
         latency       <= '0;
      end
      else
      begin
         board_valid_r <= board_valid;
         case (state)
            eval_pkg::IDLE:
            begin
               latency <= '0;
               if (board_edge)
                  state <= eval_pkg::WAIT_EVAL; // board_pre holds the board now
            end
            eval_pkg::WAIT_EVAL:
            begin
               start <= 1'b1;                    // Lands with the held board
               if (terms_valid == 3'b111)
                  state <= eval_pkg::WAIT_LATENCY;
            end
            eval_pkg::WAIT_LATENCY:
            begin
               latency <= latency + 1'b1;
               if (latency == LAT_WIDTH'(`TAPER_LATENCY - 1))
               begin
                  state      <= eval_pkg::WAIT_CLEAR;
                  eval_valid <= 1'b1;            // Blend output settled
               end
            end
            eval_pkg::WAIT_CLEAR:
            begin
               if (clear_eval)
               begin
                  state      <= eval_pkg::IDLE;
                  start      <= 1'b0;            // Evaluator valids drop next cycle
                  eval_valid <= 1'b0;
               end
            end
            default:
               state <= eval_pkg::IDLE;
         endcase
      end
   end

endmodule

/* evaluate/eval_material.sv */
`timescale 1ns/100ps
`include "eval_params.svh"

module eval_material
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  eval_pkg::board_t     board,
   output eval_pkg::eval_pair_t term,
   output logic                 insufficient_material,
   output logic                 valid
);

   // Indexed by piece code, pawn to queen
   localparam int VALUE_MG [1:5] = '{`PAWN_MG, `KNIGHT_MG, `BISHOP_MG, `ROOK_MG, `QUEEN_MG};
   localparam int VALUE_EG [1:5] = '{`PAWN_EG, `KNIGHT_EG, `BISHOP_EG, `ROOK_EG, `QUEEN_EG};

   logic [6:0] white_count [1:5];    // Up to 64 of a kind
   logic [6:0] black_count [1:5];
   logic [6:0] white_count_r [1:5];
   logic [6:0] black_count_r [1:5];
   logic       start_r;
   int         mg_sum;
   int         eg_sum;
   int         heavy_count;          // Pawns, rooks and queens
   int         minor_count;          // Knights and bishops

   // Stage 1 piece census
   always_comb
   begin
      int kind_idx;
      for (int k = 1; k <= 5; k++)
      begin
         white_count[k] = '0;
         black_count[k] = '0;
      end
      for (int s = 0; s < `SQUARE_COUNT; s++)
      begin
         kind_idx = int'(board[s].kind);
         if (kind_idx >= 1 && kind_idx <= 5)   // Empty and king skipped
         begin
            if (board[s].is_black)
               black_count[kind_idx] = black_count[kind_idx] + 1'b1;
            else
               white_count[kind_idx] = white_count[kind_idx] + 1'b1;
         end
      end
   end

   // Stage 2 weighting
   always_comb
   begin
      mg_sum = 0;
      eg_sum = 0;
      for (int k = 1; k <= 5; k++)
      begin
         mg_sum += (int'(white_count_r[k]) - int'(black_count_r[k])) * VALUE_MG[k];
         eg_sum += (int'(white_count_r[k]) - int'(black_count_r[k])) * VALUE_EG[k];
      end
      heavy_count = int'(white_count_r[1]) + int'(black_count_r[1])
                  + int'(white_count_r[4]) + int'(black_count_r[4])
                  + int'(white_count_r[5]) + int'(black_count_r[5]);
      minor_count = int'(white_count_r[2]) + int'(black_count_r[2])
                  + int'(white_count_r[3]) + int'(black_count_r[3]);
   end

   always_ff @(posedge clk)
   begin
      white_count_r         <= white_count;
      black_count_r         <= black_count;
      term.mg               <= eval_pkg::score_t'(mg_sum);  // Wraps to score width
      term.eg               <= eval_pkg::score_t'(eg_sum);
      insufficient_material <= (heavy_count == 0) && (minor_count <= 1);
   end

   // Valid follows start through both stages
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         start_r <= 1'b0;
         valid   <= 1'b0;
      end
      else
      begin
         start_r <= start;
         valid   <= start & start_r;
      end
   end

endmodule

/* evaluate/eval_pawns.sv */
`timescale 1ns/100ps
`include "eval_params.svh"

module eval_pawns
#(
   parameter int WHITE_SIDE = 1         // 1 scores white pawns, 0 black
)
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  eval_pkg::board_t     board,
   output eval_pkg::eval_pair_t term,
   output logic                 valid
);

   localparam logic SIDE_BLACK = (WHITE_SIDE == 0);

   logic [3:0] file_count [8];          // Own pawns per file, a to h
   logic [3:0] file_count_r [8];
   logic [7:0] has_pawn;
   logic [7:0] adjacent;                // Own pawn on a neighbour file
   logic       start_r;
   int         doubled;
   int         isolated;
   int         pen_mg;
   int         pen_eg;

   // Stage 1 file census
   always_comb
   begin
      for (int f = 0; f < 8; f++)
         file_count[f] = '0;
      for (int s = 0; s < `SQUARE_COUNT; s++)
      begin
         if (board[s].kind == eval_pkg::PAWN && board[s].is_black == SIDE_BLACK)
            file_count[s % 8] = file_count[s % 8] + 1'b1;
      end
   end

   always_comb
   begin
      for (int f = 0; f < 8; f++)
         has_pawn[f] = (file_count_r[f] != '0);
   end

   // Bit f sees files f - 1 and f + 1, edges see only one
   assign adjacent = (has_pawn << 1) | (has_pawn >> 1);

   // Stage 2 penalty count
   always_comb
   begin
      doubled  = 0;
      isolated = 0;
      for (int f = 0; f < 8; f++)
      begin
         if (has_pawn[f])
            doubled += int'(file_count_r[f]) - 1;   // Extra pawns stacked on file
         if (!adjacent[f])
            isolated += int'(file_count_r[f]);      // Every pawn of a lone file
      end
      pen_mg = doubled * `DOUBLED_MG + isolated * `ISOLATED_MG;
      pen_eg = doubled * `DOUBLED_EG + isolated * `ISOLATED_EG;
   end

   always_ff @(posedge clk)
   begin
      file_count_r <= file_count;
      term.mg      <= eval_pkg::score_t'((WHITE_SIDE != 0) ? -pen_mg : pen_mg);
      term.eg      <= eval_pkg::score_t'((WHITE_SIDE != 0) ? -pen_eg : pen_eg);
   end

   // Same two-cycle valid as the material block
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         start_r <= 1'b0;
         valid   <= 1'b0;
      end
      else
      begin
         start_r <= start;
         valid   <= start & start_r;
      end
   end

endmodule

/* evaluate/eval_taper.sv */
`timescale 1ns/100ps
`include "eval_params.svh"

module eval_taper
(
   input  logic                 clk,
   input  logic                 reset,
   input  eval_pkg::eval_pair_t material,
   input  eval_pkg::eval_pair_t pawns_white,
   input  eval_pkg::eval_pair_t pawns_black,
   input  eval_pkg::board_t     board,
   output eval_pkg::score_t     eval
);

   localparam int PHASE_W = $bits(eval_pkg::phase_t);
   localparam int SUM_W   = `EVAL_WIDTH + 2;                // Three terms summed
   localparam int PROD_W  = SUM_W + PHASE_W + 1;            // Phase as signed operand
   localparam int BLEND_W = PROD_W + 1;
   localparam int SCALE_W = BLEND_W + `TAPER_SHIFT + 1;     // Reciprocal below 2^SHIFT

   localparam logic signed [SCALE_W-1:0] RECIP = `TAPER_RECIP;
   localparam logic signed [SCALE_W-1:0] BIAS  = (1 << `TAPER_SHIFT) - 1;

   logic [6:0]                  occupied_count;             // 0 to 64
   eval_pkg::phase_t            phase_next;
   eval_pkg::phase_t            phase_t1;
   eval_pkg::phase_t            phase_comp;                 // End-game weight
   logic signed [SUM_W-1:0]     mg_sum_t1;
   logic signed [SUM_W-1:0]     eg_sum_t1;
   logic signed [PROD_W-1:0]    mg_prod_t2;
   logic signed [PROD_W-1:0]    eg_prod_t2;
   logic signed [BLEND_W-1:0]   blend_t3;
   logic signed [SCALE_W-1:0]   scaled_t4;
   logic signed [SCALE_W-1:0]   rounded;

   always_comb
   begin
      occupied_count = '0;
      for (int s = 0; s < `SQUARE_COUNT; s++)
      begin
         if (board[s].kind != eval_pkg::EMPTY)
            occupied_count = occupied_count + 1'b1;
      end
   end

   assign phase_next = (occupied_count > 7'(`PHASE_MAX))
                     ? eval_pkg::phase_t'(`PHASE_MAX)        // Limit at full board
                     : occupied_count[PHASE_W-1:0];
   assign phase_comp = eval_pkg::phase_t'(`PHASE_MAX) - phase_t1;

   // Negative values get a bias so the shift truncates toward zero
   assign rounded = scaled_t4 + (scaled_t4[SCALE_W-1] ? BIAS : '0);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         phase_t1   <= '0;
         mg_sum_t1  <= '0;
         eg_sum_t1  <= '0;
         mg_prod_t2 <= '0;
         eg_prod_t2 <= '0;
         blend_t3   <= '0;
         scaled_t4  <= '0;
         eval       <= '0;
      end
      else
      begin
         phase_t1   <= phase_next;
         mg_sum_t1  <= $signed(material.mg) + $signed(pawns_white.mg) + $signed(pawns_black.mg);
         eg_sum_t1  <= $signed(material.eg) + $signed(pawns_white.eg) + $signed(pawns_black.eg);
         mg_prod_t2 <= mg_sum_t1 * $signed({1'b0, phase_t1});
         eg_prod_t2 <= eg_sum_t1 * $signed({1'b0, phase_comp});
         blend_t3   <= mg_prod_t2 + eg_prod_t2;
         scaled_t4  <= blend_t3 * RECIP;                        // Times 1/62 in fixed point
         eval       <= rounded[`TAPER_SHIFT +: `EVAL_WIDTH];    // Drop fraction bits
      end
   end

endmodule

/* evaluate/evaluate.sv */
`timescale 1ns/100ps

module evaluate
(
   input  logic              clk,
   input  logic              reset,
   input  logic              board_valid,     // Level, rising edge starts a run
   input  eval_pkg::board_t  board_in,
   input  logic              clear_eval,      // Releases the held result
   output eval_pkg::score_t  eval,
   output logic              eval_valid,
   output logic              insufficient_material
);

   eval_pkg::board_t      board;              // Held board for all evaluators
   eval_pkg::eval_pair_t  material_term;
   eval_pkg::eval_pair_t  pawns_white_term;
   eval_pkg::eval_pair_t  pawns_black_term;
   logic                  start;
   logic                  material_valid;
   logic                  pawns_white_valid;
   logic                  pawns_black_valid;

   eval_control u_control
   (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .board_in    (board_in),
      .clear_eval  (clear_eval),
      .terms_valid ({pawns_black_valid, pawns_white_valid, material_valid}),
      .board       (board),
      .start       (start),
      .eval_valid  (eval_valid)
   );

   eval_material u_material
   (
      .clk                   (clk),
      .reset                 (reset),
      .start                 (start),
      .board                 (board),
      .term                  (material_term),
      .insufficient_material (insufficient_material),
      .valid                 (material_valid)
   );

   eval_pawns #(.WHITE_SIDE(1)) u_pawns_white
   (
      .clk   (clk),
      .reset (reset),
      .start (start),
      .board (board),
      .term  (pawns_white_term),
      .valid (pawns_white_valid)
   );

   eval_pawns #(.WHITE_SIDE(0)) u_pawns_black
   (
      .clk   (clk),
      .reset (reset),
      .start (start),
      .board (board),
      .term  (pawns_black_term),
      .valid (pawns_black_valid)
   );

   eval_taper u_taper
   (
      .clk         (clk),
      .reset       (reset),
      .material    (material_term),
      .pawns_white (pawns_white_term),
      .pawns_black (pawns_black_term),
      .board       (board),
      .eval        (eval)
   );

endmodule

/* run_sim.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -Wno-fatal --top-module tb_evaluate -f sources.f
output=$(./obj_dir/Vtb_evaluate)
echo "$output"

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
   exit 0
fi
exit 1

/* sources.f */
+incdir+common
common/eval_pkg.sv
evaluate/eval_control.sv
evaluate/eval_material.sv
evaluate/eval_pawns.sv
evaluate/eval_taper.sv
evaluate/evaluate.sv
verif/tb_evaluate.sv

/* verif/tb_evaluate.sv */
`timescale 1ns/100ps
`include "eval_params.svh"

module tb_evaluate;

   localparam int CLK_PERIOD = 100;
   localparam int TABLE_SIZE = 8;
   localparam int RANDOM_COUNT = 8;
   localparam int TEST_COUNT = TABLE_SIZE + RANDOM_COUNT + 1;  // Plus the reset check
   localparam int RESULT_TIMEOUT = 30;                         // Cycles to wait for eval_valid
   localparam int WATCHDOG_CYCLES = 60 * TEST_COUNT;

   logic                clk;
   logic                reset;
   logic                board_valid;
   eval_pkg::board_t    board_in;
   logic                clear_eval;
   eval_pkg::score_t    eval;
   logic                eval_valid;
   logic                insufficient_material;
   logic [31:0]         rand_state;
   int                  mismatch_count;
   int                  timeout_count;

   // Placement i in bits [16*i +: 16] as 'hSSCK, square, colour, kind; kind 0 is unused
   string        table_name [TABLE_SIZE] = '{"kings_only", "even_material",
      "white_doubled_isolated", "black_doubled_isolated", "lone_queen",
      "king_knight_vs_king", "single_pawn", "bishop_each_side"};
   logic [127:0] table_places [TABLE_SIZE] = '{
      128'h0000_0000_0000_0000_0000_0000_3C16_0406,
      128'h3E12_0602_3311_3411_0B01_0C01_3C16_0406,
      128'h0000_0000_3311_0F01_1001_0801_3C16_0406,
      128'h0000_0901_3511_2211_2A11_3211_3C16_0406,
      128'h0000_0000_0000_0000_0000_0305_3C16_0406,
      128'h0000_0000_0000_0000_0000_0602_3C16_0406,
      128'h0000_0000_0000_0000_0000_0C01_3C16_0406,
      128'h0000_0000_0000_0000_3D13_0203_3C16_0406};
   logic         table_insuff [TABLE_SIZE] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

   evaluate uut
   (
      .clk                   (clk),
      .reset                 (reset),
      .board_valid           (board_valid),
      .board_in              (board_in),
      .clear_eval            (clear_eval),
      .eval                  (eval),
      .eval_valid            (eval_valid),
      .insufficient_material (insufficient_material)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   function automatic eval_pkg::board_t build_board(input logic [127:0] places);
      eval_pkg::board_t b;
      logic [15:0]      p;
      b = '0;
      for (int i = 0; i < 8; i++)
      begin
         p = places[16*i +: 16];
         if (p[2:0] != 3'd0)
            b[int'(p[13:8])] = eval_pkg::square_t'({p[4], p[2:0]});
      end
      return b;
   endfunction

   // Sparse boards take 8 placements, full boards fill every square
   function automatic eval_pkg::board_t random_board(input bit full);
      eval_pkg::board_t b;
      logic [31:0]      r;
      b = '0;
      for (int i = 0; i < (full ? `SQUARE_COUNT : 8); i++)
      begin
         r = lcg_next();
         b[full ? i : int'(r[29:24])] =
            eval_pkg::square_t'({r[31], 3'(1 + int'(r[23:16]) % 6)});
      end
      return b;
   endfunction

   function automatic int piece_value(input eval_pkg::piece_t kind, input bit end_game);
      case (kind)
         eval_pkg::PAWN:   return end_game ? `PAWN_EG : `PAWN_MG;
         eval_pkg::KNIGHT: return end_game ? `KNIGHT_EG : `KNIGHT_MG;
         eval_pkg::BISHOP: return end_game ? `BISHOP_EG : `BISHOP_MG;
         eval_pkg::ROOK:   return end_game ? `ROOK_EG : `ROOK_MG;
         eval_pkg::QUEEN:  return end_game ? `QUEEN_EG : `QUEEN_MG;
         default:          return 0;                         // Empty and king
      endcase
   endfunction

   function automatic int wrap_score(input int value);
      eval_pkg::score_t s;
      s = eval_pkg::score_t'(value);                         // Keep score width, sign extend back
      return int'(s);
   endfunction

   // Positive penalty of one side, sign applied by the caller
   function automatic void pawn_penalty(input eval_pkg::board_t b, input bit black,
                                        output int mg, output int eg);
      int count [8];
      int doubled;
      int isolated;
      int left;
      int right;
      doubled = 0;
      isolated = 0;
      for (int f = 0; f < 8; f++)
         count[f] = 0;
      for (int s = 0; s < `SQUARE_COUNT; s++)
         if (b[s].kind == eval_pkg::PAWN && b[s].is_black == black)
            count[s % 8]++;
      for (int f = 0; f < 8; f++)
      begin
         left = (f > 0) ? count[f-1] : 0;
         right = (f < 7) ? count[f+1] : 0;
         if (count[f] > 0)
            doubled += count[f] - 1;
         if (left == 0 && right == 0)
            isolated += count[f];
      end
      mg = doubled * `DOUBLED_MG + isolated * `ISOLATED_MG;
      eg = doubled * `DOUBLED_EG + isolated * `ISOLATED_EG;
   endfunction

   function automatic eval_pkg::score_t model_eval(input eval_pkg::board_t b);
      int     mat_mg;
      int     mat_eg;
      int     white_mg;
      int     white_eg;
      int     black_mg;
      int     black_eg;
      int     occupied;
      int     phase;
      longint mg_sum;
      longint eg_sum;
      longint scaled;
      mat_mg = 0;
      mat_eg = 0;
      occupied = 0;
      for (int s = 0; s < `SQUARE_COUNT; s++)
      begin
         mat_mg += b[s].is_black ? -piece_value(b[s].kind, 0) : piece_value(b[s].kind, 0);
         mat_eg += b[s].is_black ? -piece_value(b[s].kind, 1) : piece_value(b[s].kind, 1);
         if (b[s].kind != eval_pkg::EMPTY)
            occupied++;
      end
      pawn_penalty(b, 1'b0, white_mg, white_eg);
      pawn_penalty(b, 1'b1, black_mg, black_eg);
      mg_sum = wrap_score(mat_mg) + wrap_score(-white_mg) + wrap_score(black_mg);
      eg_sum = wrap_score(mat_eg) + wrap_score(-white_eg) + wrap_score(black_eg);
      phase = (occupied > `PHASE_MAX) ? `PHASE_MAX : occupied;  // Full board limited
      scaled = (mg_sum * phase + eg_sum * (`PHASE_MAX - phase)) * `TAPER_RECIP;
      return eval_pkg::score_t'(scaled / (longint'(1) <<< `TAPER_SHIFT)); // Toward zero
   endfunction

   function automatic logic model_insufficient(input eval_pkg::board_t b);
      int heavy;
      int minor;
      heavy = 0;
      minor = 0;
      for (int s = 0; s < `SQUARE_COUNT; s++)
      begin
         if (b[s].kind inside {eval_pkg::PAWN, eval_pkg::ROOK, eval_pkg::QUEEN})
            heavy++;
         if (b[s].kind inside {eval_pkg::KNIGHT, eval_pkg::BISHOP})
            minor++;
      end
      return (heavy == 0) && (minor <= 1);
   endfunction

   task automatic check_score(input string name, input eval_pkg::score_t expected,
                              input eval_pkg::score_t actual);
      if (actual !== expected)
      begin
         mismatch_count++;
         $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         mismatch_count++;
         $display("mismatch %s: expected %0b, actual %0b", name, expected, actual);
      end
   endtask

   // One evaluation, hold under a changing board, clear, and no restart on a held level
   task automatic run_test(input string name, input eval_pkg::board_t b, input logic insuff);
      eval_pkg::score_t expected;
      int               waited;
      expected = model_eval(b);
      @(posedge clk);
      board_in <= b;
      board_valid <= 1'b1;                                   // Rising edge starts a run
      waited = 0;
      @(negedge clk);
      while (!eval_valid && waited < RESULT_TIMEOUT)
      begin
         @(negedge clk);
         waited++;
      end
      if (!eval_valid)
      begin
         timeout_count++;
         $display("error %s: eval_valid did not rise within %0d cycles", name, RESULT_TIMEOUT);
      end
      else
      begin
         check_score(name, expected, eval);
         check_flag($sformatf("%s_insufficient", name), insuff, insufficient_material);
         for (int k = 0; k < 10; k++)
         begin
            @(posedge clk);
            board_in <= k[0] ? '0 : {`SQUARE_COUNT{4'b1101}};  // Black queens, then empty
            @(negedge clk);
            check_score($sformatf("%s_hold", name), expected, eval);
            check_flag($sformatf("%s_hold_valid", name), 1'b1, eval_valid);
         end
      end
      @(posedge clk);
      clear_eval <= 1'b1;
      @(posedge clk);
      clear_eval <= 1'b0;
      @(negedge clk);
      check_flag($sformatf("%s_cleared", name), 1'b0, eval_valid);
      repeat (12)
      begin
         @(negedge clk);                                     // board_valid still high
         check_flag($sformatf("%s_no_restart", name), 1'b0, eval_valid);
      end
      @(posedge clk);
      board_valid <= 1'b0;
      repeat (2) @(posedge clk);
   endtask

   initial
   begin
      eval_pkg::board_t b;
      reset = 1'b1;
      board_valid = 1'b0;
      board_in = '0;
      clear_eval = 1'b0;
      rand_state = 32'h3926_9885;
      mismatch_count = 0;
      timeout_count = 0;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      repeat (12)
      begin
         @(negedge clk);
         check_flag("idle_after_reset", 1'b0, eval_valid);
      end
      for (int t = 0; t < TABLE_SIZE; t++)
         run_test(table_name[t], build_board(table_places[t]), table_insuff[t]);
      for (int n = 0; n < RANDOM_COUNT; n++)
      begin
         b = random_board(n >= RANDOM_COUNT - 2);            // Last two fill the board
         run_test($sformatf("random_%0d", n), b, model_insufficient(b));
      end
      $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
      if (mismatch_count == 0 && timeout_count == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("error: watchdog expired after %0d cycles, the run did not finish",
               WATCHDOG_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule
